/* build.sh */
#!/bin/sh
# Build and run the RH11 DMA channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rhTb -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/VrhTb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q -F '*** PASSED ***'; then
   exit 0
fi
exit 1

/* design/rhCsr.sv */
/*
 * RH11 register block
 * Write decode, CS1 state, transfer start, interrupt and read mux
 */
module rhCsr
(
   input  logic             clk,
   input  logic             rst,
   input  logic             regWrite,
   input  rhPkg::rhBusReqT  busReq,
   input  rhPkg::rhAddrT    regAddr,
   input  logic [15:0]      wc,
   input  logic [15:0]      ba,
   input  logic             xferDone,
   output logic [15:0]      regRdData,
   output logic             wcWrite,
   output logic             baWrite,
   output logic             loByte,
   output logic             hiByte,
   output logic [15:0]      wrData,
   output logic             clr,
   output logic             start,
   output logic             intr
);

   rhPkg::rhCs1T     wrCs1;
   rhPkg::rhRegWordT rdWord;
   rhPkg::rhFuncT    func;
   logic             ie;
   logic             rdy;
   logic             err;
   logic             cs1Write;
   logic             goWrite;

   //////////////////////////////
   // Write decode
   //////////////////////////////

   // CS1 field view of the write word
   assign wrCs1    = busReq.data.cs1;
   assign cs1Write = regWrite && (busReq.addr == rhPkg::rhAddrCs1);

   // Controller clear lives in the high byte
   assign clr = cs1Write && busReq.hiByte && wrCs1.clr;

   // GO only counts when idle
   assign goWrite = cs1Write && busReq.loByte && wrCs1.go && rdy && !clr;
   assign start   = goWrite && (wrCs1.func == rhPkg::rhFuncRead);

   // Counter loads only while no transfer runs
   assign wcWrite = regWrite && (busReq.addr == rhPkg::rhAddrWc) && rdy;
   assign baWrite = regWrite && (busReq.addr == rhPkg::rhAddrBa) && rdy;

   // Shared lanes and raw data to both counters
   assign loByte = busReq.loByte;
   assign hiByte = busReq.hiByte;
   assign wrData = busReq.data.raw;

   //////////////////////////////
   // CS1 state
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         func <= rhPkg::rhFuncNop;
         ie   <= 1'b0;
         rdy  <= 1'b1;
         err  <= 1'b0;
         intr <= 1'b0;
      end
      else if (clr)
      begin
         // Back to idle with the error dropped
         func <= rhPkg::rhFuncNop;
         ie   <= 1'b0;
         rdy  <= 1'b1;
         err  <= 1'b0;
         intr <= 1'b0;
      end
      else
      begin
         // One-cycle interrupt on completion
         intr <= xferDone && ie;
         if (xferDone)
            rdy <= 1'b1;
         else if (start)
            rdy <= 1'b0;
         // GO with anything but read
         if (goWrite && !start)
            err <= 1'b1;
         if (cs1Write && busReq.loByte)
         begin
            ie <= wrCs1.ie;
            // Function frozen during a transfer
            if (rdy)
               func <= wrCs1.func;
         end
      end
   end

   //////////////////////////////
   // Read mux
   //////////////////////////////

   always_comb
   begin
      rdWord = '0;
      case (regAddr)
         rhPkg::rhAddrCs1:
         begin
            // GO reads back as busy
            rdWord.cs1.go   = !rdy;
            rdWord.cs1.func = func;
            rdWord.cs1.ie   = ie;
            rdWord.cs1.rdy  = rdy;
            rdWord.cs1.clr  = err;
         end
         rhPkg::rhAddrWc:
            rdWord.raw = wc;
         rhPkg::rhAddrBa:
            rdWord.raw = ba;
         default:
            rdWord.raw = '0;
      endcase
   end

   assign regRdData = rdWord.raw;

   // Ready stays low for the whole transfer, so completion only comes while it is clear
   rhCsrDoneBusy : assert property (@(posedge clk) disable iff (rst) xferDone |-> !rdy)
      else $error("transfer completion while ready");

endmodule

/* design/rhPkg.sv */
/*
 * RH11 DMA channel shared definitions
 * Register map, function codes and the words passed between blocks
 */
package rhPkg;

   //////////////////////////////
   // Register select
   //////////////////////////////

   typedef logic [1:0] rhAddrT;

   // Control and status
   localparam rhAddrT rhAddrCs1 = 2'd0;
   // Word count
   localparam rhAddrT rhAddrWc  = 2'd1;
   // Bus address
   localparam rhAddrT rhAddrBa  = 2'd2;

   //////////////////////////////
   // Function codes
   //////////////////////////////

   typedef logic [4:0] rhFuncT;

   localparam rhFuncT rhFuncNop  = 5'o00;
   // Read data, device to memory
   localparam rhFuncT rhFuncRead = 5'o34;

   //////////////////////////////
   // Register words
   //////////////////////////////

   // CS1 field view, bit 15 is clear on write and transfer error on read
   typedef struct packed
   {
      logic         clr;
      logic [6:0]   spare;
      logic         rdy;
      logic         ie;
      rhFuncT       func;
      logic         go;
   } rhCs1T;

   // Same bus word seen as CS1 fields or as a raw count/address
   typedef union packed
   {
      rhCs1T        cs1;
      logic [15:0]  raw;
   } rhRegWordT;

   // Register write request
   typedef struct packed
   {
      rhAddrT       addr;
      logic         loByte;
      logic         hiByte;
      rhRegWordT    data;
   } rhBusReqT;

   // Memory write request
   typedef struct packed
   {
      logic [15:0]  addr;
      logic [35:0]  data;
   } rhMemReqT;

   // Bus address counter width
   localparam int rhBaWidthDefault = 16;

endpackage

/* design/rhSequencer.sv */
/*
 * RH11 transfer sequencer
 * Turns device word strobes into memory writes until the count wraps
 */
module rhSequencer
(
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  logic             start,
   input  logic             devStrobe,
   input  logic [35:0]      devWord,
   input  logic [15:0]      ba,
   input  logic             wcLast,
   output logic             memWrite,
   output rhPkg::rhMemReqT  memReq,
   output logic             incWc,
   output logic             incBa,
   output logic             xferDone
);

   typedef enum logic [1:0]
   {
      stIdle,
      stBusy,
      stDone
   } stateT;

   stateT state;
   stateT stateNext;
   logic  accept;

   // Device word taken this cycle
   assign accept = (state == stBusy) && devStrobe && !clr;

   //////////////////////////////
   // State machine
   //////////////////////////////

   always_comb
   begin
      stateNext = state;
      if (clr)
      begin
         stateNext = stIdle;
      end
      else
      begin
         case (state)
            stIdle:
               if (start)
                  stateNext = stBusy;
            stBusy:
               // Word that wraps the count ends the transfer
               if (accept && wcLast)
                  stateNext = stDone;
            stDone:
               stateNext = stIdle;
            default:
               stateNext = stIdle;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= stIdle;
         memWrite <= 1'b0;
      end
      else
      begin
         state    <= stateNext;
         memWrite <= accept;
      end
   end

   // Request holds the address before its increment
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         memReq.addr <= ba;
         memReq.data <= devWord;
      end
   end

   // Counters step on the same edge that captures the request
   assign incWc = accept;
   assign incBa = accept;

   // Completion strobe to the register block
   assign xferDone = (state == stDone);

   // Register block only starts a transfer once the last one has wound down
   rhSeqStartIdle : assert property (@(posedge clk) disable iff (rst)
      start |-> state == stIdle)
      else $error("transfer start while the sequencer is not idle");

endmodule

/* design/rhTop.sv */
/*
 * RH11 DMA channel top level
 * Register block, word count, bus address and sequencer
 */
module rhTop
#(
   parameter int BaWidth = rhPkg::rhBaWidthDefault
)
(
   input  logic             clk,
   input  logic             rst,
   input  logic             regWrite,
   input  rhPkg::rhBusReqT  busReq,
   input  rhPkg::rhAddrT    regAddr,
   input  logic             devStrobe,
   input  logic [35:0]      devWord,
   output logic [15:0]      regRdData,
   output logic             memWrite,
   output rhPkg::rhMemReqT  memReq,
   output logic             intr
);

   // Register block to counters
   logic               wcWrite;
   logic               baWrite;
   logic               loByte;
   logic               hiByte;
   logic [15:0]        wrData;
   logic               clr;
   logic               start;

   // Counters and sequencer
   logic [15:0]        wc;
   logic               wcLast;
   logic [BaWidth-1:0] ba;
   logic [15:0]        ba16;
   logic               incWc;
   logic               incBa;
   logic               xferDone;

   // Bus address on the 16-bit register and memory paths
   assign ba16 = 16'(ba);

   rhCsr uCsr
   (
      .clk       (clk),
      .rst       (rst),
      .regWrite  (regWrite),
      .busReq    (busReq),
      .regAddr   (regAddr),
      .wc        (wc),
      .ba        (ba16),
      .xferDone  (xferDone),
      .regRdData (regRdData),
      .wcWrite   (wcWrite),
      .baWrite   (baWrite),
      .loByte    (loByte),
      .hiByte    (hiByte),
      .wrData    (wrData),
      .clr       (clr),
      .start     (start),
      .intr      (intr)
   );

   rhwc uWc
   (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .wcWrite (wcWrite),
      .loByte  (loByte),
      .hiByte  (hiByte),
      .wrData  (wrData),
      .incWc   (incWc),
      .wc      (wc),
      .wcLast  (wcLast)
   );

   rhba #(.BaWidth(BaWidth)) uBa
   (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .baWrite (baWrite),
      .loByte  (loByte),
      .hiByte  (hiByte),
      .wrData  (wrData),
      .incBa   (incBa),
      .ba      (ba)
   );

   rhSequencer uSeq
   (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .start     (start),
      .devStrobe (devStrobe),
      .devWord   (devWord),
      .ba        (ba16),
      .wcLast    (wcLast),
      .memWrite  (memWrite),
      .memReq    (memReq),
      .incWc     (incWc),
      .incBa     (incBa),
      .xferDone  (xferDone)
   );

endmodule

/* design/rhba.sv */
/*
 * RH11 bus address register
 * Byte-lane loadable address counter, wraps modulo its width
 */
module rhba
#(
   parameter int BaWidth = rhPkg::rhBaWidthDefault
)
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  logic               baWrite,
   input  logic               loByte,
   input  logic               hiByte,
   input  logic [15:0]        wrData,
   input  logic               incBa,
   output logic [BaWidth-1:0] ba
);

   logic [15:0] baView;
   logic [15:0] baMerged;

   // Register seen through the 16-bit bus
   assign baView = 16'(ba);

   // Lane merge of write data over the current value
   always_comb
   begin
      baMerged = baView;
      if (hiByte)
         baMerged[15:8] = wrData[15:8];
      if (loByte)
         baMerged[7:0] = wrData[7:0];
   end

   // Clear first, then write, then increment
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ba <= '0;
      else if (clr)
         ba <= '0;
      else if (baWrite)
         ba <= BaWidth'(baMerged);
      else if (incBa)
         ba <= ba + BaWidth'(1);
   end

   // Address writes are held off while the sequencer is stepping
   rhbaNoIncOnWrite : assert property (@(posedge clk) disable iff (rst) !(incBa && baWrite))
      else $error("bus address increment during register write");

endmodule

/* design/rhwc.sv */
/*
 * RH11 word count register
 * Byte-lane loadable up-counter holding the negated transfer length
 */
module rhwc
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic        wcWrite,
   input  logic        loByte,
   input  logic        hiByte,
   input  logic [15:0] wrData,
   input  logic        incWc,
   output logic [15:0] wc,
   output logic        wcLast
);

   // Clear first, then write, then increment
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wc <= '0;
      end
      else if (clr)
      begin
         wc <= '0;
      end
      else if (wcWrite)
      begin
         // Each lane loads on its own
         if (hiByte)
            wc[15:8] <= wrData[15:8];
         if (loByte)
            wc[7:0] <= wrData[7:0];
      end
      else if (incWc)
      begin
         wc <= wc + 16'd1;
      end
   end

   // Count of all ones, next increment wraps to zero
   assign wcLast = &wc;

   // Sequencer never steps the count on a controller clear
   rhwcNoIncOnClr : assert property (@(posedge clk) disable iff (rst) !(clr && incWc))
      else $error("word count increment during clear");

endmodule

/* sim.f */
design/rhPkg.sv
design/rhwc.sv
design/rhba.sv
design/rhCsr.sv
design/rhSequencer.sv
design/rhTop.sv
verification/rhTb.sv

/* verification/rhTb.sv */
/*
 * RH11 DMA channel testbench
 * Table of transfers, register bus tasks, LFSR device data, memory write monitor
 */
module rhTb;

   typedef struct packed
   {
      logic [15:0]   startBa;
      logic [15:0]   wcInit;
      logic          ie;
      rhPkg::rhFuncT func;
      logic          xfer;
   } xferEntryT;

   localparam int numXfers     = 5;
   localparam int readyTimeout = 200;

   // Start BA, negated length, ie, function, transfer expected
   localparam xferEntryT xferTable [numXfers] = '{
      '{16'h0100, 16'hFFFC, 1'b1, rhPkg::rhFuncRead, 1'b1},
      '{16'hFFFE, 16'hFFFB, 1'b0, rhPkg::rhFuncRead, 1'b1},
      '{16'h1234, 16'hFFFF, 1'b1, rhPkg::rhFuncRead, 1'b1},
      '{16'h0040, 16'hFFFD, 1'b1, 5'o07,             1'b0},
      '{16'h2000, 16'hFFF8, 1'b1, rhPkg::rhFuncRead, 1'b1}
   };

   logic             clk;
   logic             rst;
   logic             regWrite;
   rhPkg::rhBusReqT  busReq;
   rhPkg::rhAddrT    regAddr;
   logic             devStrobe;
   logic [35:0]      devWord;
   logic [15:0]      regRdData;
   logic             memWrite;
   rhPkg::rhMemReqT  memReq;
   logic             intr;

   logic [16:0]      lfsr;
   // Expected memory writes, oldest first
   logic [15:0]      expAddr [$];
   logic [35:0]      expData [$];
   int               errors;
   int               timeouts;
   int               writeCount;
   int               intrCount;

   rhTop #(.BaWidth(rhPkg::rhBaWidthDefault)) UUT
   (
      .clk       (clk),
      .rst       (rst),
      .regWrite  (regWrite),
      .busReq    (busReq),
      .regAddr   (regAddr),
      .devStrobe (devStrobe),
      .devWord   (devWord),
      .regRdData (regRdData),
      .memWrite  (memWrite),
      .memReq    (memReq),
      .intr      (intr)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // 17-bit Fibonacci LFSR, taps 17 and 14
   function automatic logic [16:0] lfsrNext(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   // One LFSR step per data bit
   task automatic makeWord(output logic [35:0] w);
      for (int i = 0; i < 36; i++)
      begin
         lfsr = lfsrNext(lfsr);
         w[i] = lfsr[0];
      end
   endtask

   // Byte-lane rule, each enabled lane replaces its byte
   function automatic logic [15:0] mergeLanes(input logic [15:0] old, input logic [15:0] data,
                                              input logic lo, input logic hi);
      logic [15:0] m;
      m = old;
      if (lo)
         m[7:0] = data[7:0];
      if (hi)
         m[15:8] = data[15:8];
      return m;
   endfunction

   task automatic writeReg(input rhPkg::rhAddrT a, input logic lo, input logic hi,
                           input logic [15:0] d);
      @(negedge clk);
      regWrite         = 1'b1;
      busReq.addr      = a;
      busReq.loByte    = lo;
      busReq.hiByte    = hi;
      busReq.data.raw  = d;
      @(negedge clk);
      regWrite = 1'b0;
   endtask

   // Read mux is combinational, sample shortly after the address settles
   task automatic readReg(input rhPkg::rhAddrT a, output logic [15:0] d);
      @(negedge clk);
      regAddr = a;
      #1;
      d = regRdData;
   endtask

   task automatic expectReg(input rhPkg::rhAddrT a, input logic [15:0] exp, input string name);
      logic [15:0] d;
      readReg(a, d);
      if (d !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, d);
      end
   endtask

   // Device strobes, optionally recorded as expected memory writes
   task automatic sendWords(input int n, input logic gap, input logic tracked,
                            input logic [15:0] base);
      logic [35:0] w;
      for (int k = 0; k < n; k++)
      begin
         makeWord(w);
         if (tracked)
         begin
            expAddr.push_back(16'(base + k));
            expData.push_back(w);
         end
         @(negedge clk);
         devStrobe = 1'b1;
         devWord   = w;
         if (gap)
         begin
            @(negedge clk);
            devStrobe = 1'b0;
         end
      end
      @(negedge clk);
      devStrobe = 1'b0;
   endtask

   // Poll CS1 until rdy comes back
   task automatic waitReady(input int idx);
      logic [15:0] d;
      int          n;
      logic        seen;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < readyTimeout)
      begin
         readReg(rhPkg::rhAddrCs1, d);
         seen = d[7];
         n++;
      end
      if (!seen)
      begin
         timeouts++;
         $display("timeout: transfer %0d never returned to ready", idx);
      end
   endtask

   // Full, low-only, high-only and empty lane writes
   task automatic laneTest(input rhPkg::rhAddrT a, input string name);
      logic [15:0] model;
      writeReg(a, 1'b1, 1'b1, 16'h1357);
      model = 16'h1357;
      expectReg(a, model, name);
      writeReg(a, 1'b1, 1'b0, 16'hA55A);
      model = mergeLanes(model, 16'hA55A, 1'b1, 1'b0);
      expectReg(a, model, name);
      writeReg(a, 1'b0, 1'b1, 16'h3CC3);
      model = mergeLanes(model, 16'h3CC3, 1'b0, 1'b1);
      expectReg(a, model, name);
      writeReg(a, 1'b0, 1'b0, 16'hFFFF);
      expectReg(a, model, name);
   endtask

   //////////////////////////////
   // One table entry
   //////////////////////////////

   task automatic runXfer(input int idx);
      xferEntryT        e;
      rhPkg::rhRegWordT cs;
      logic [15:0]      csExp;
      int               len;
      int               writesBefore;
      e   = xferTable[idx];
      len = 65536 - int'(e.wcInit);
      writeReg(rhPkg::rhAddrWc, 1'b1, 1'b1, e.wcInit);
      writeReg(rhPkg::rhAddrBa, 1'b1, 1'b1, e.startBa);
      expectReg(rhPkg::rhAddrWc, e.wcInit, "WC");
      expectReg(rhPkg::rhAddrBa, e.startBa, "BA");
      // GO word through the CS1 field view
      cs.raw      = '0;
      cs.cs1.go   = 1'b1;
      cs.cs1.func = e.func;
      cs.cs1.ie   = e.ie;
      writeCount  = 0;
      intrCount   = 0;
      writeReg(rhPkg::rhAddrCs1, 1'b1, 1'b1, cs.raw);
      if (e.xfer)
      begin
         // Busy: go reads 1, rdy 0
         csExp = {1'b0, 7'd0, 1'b0, e.ie, e.func, 1'b1};
         expectReg(rhPkg::rhAddrCs1, csExp, "CS1");
         // Odd entries leave a gap between strobes
         sendWords(len, (idx % 2) != 0, 1'b1, e.startBa);
         waitReady(idx);
         // Last memWrite and intr settle within a cycle of rdy
         repeat (2) @(negedge clk);
         if (writeCount != len)
         begin
            errors++;
            $display("mismatch at %0t: memWrite count expected %0d got %0d", $time, len,
                     writeCount);
         end
         if (expAddr.size() != 0)
         begin
            errors++;
            $display("transfer %0d ended with %0d device words never written to memory", idx,
                     expAddr.size());
            expAddr.delete();
            expData.delete();
         end
         if (intrCount != int'(e.ie))
         begin
            errors++;
            $display("mismatch at %0t: intr pulses expected %0d got %0d", $time, int'(e.ie),
                     intrCount);
         end
         expectReg(rhPkg::rhAddrWc, 16'h0000, "WC");
         expectReg(rhPkg::rhAddrBa, 16'(e.startBa + len), "BA");
         csExp = {1'b0, 7'd0, 1'b1, e.ie, e.func, 1'b0};
         expectReg(rhPkg::rhAddrCs1, csExp, "CS1");
         // Strobes while idle go nowhere
         writesBefore = writeCount;
         sendWords(2, 1'b1, 1'b0, 16'h0000);
         repeat (2) @(negedge clk);
         if (writeCount != writesBefore)
         begin
            errors++;
            $display("device strobes while idle produced memory writes");
         end
      end
      else
      begin
         // Error flag up, still ready
         csExp = {1'b1, 7'd0, 1'b1, e.ie, e.func, 1'b0};
         expectReg(rhPkg::rhAddrCs1, csExp, "CS1");
         sendWords(2, 1'b0, 1'b0, 16'h0000);
         repeat (2) @(negedge clk);
         if (writeCount != 0)
         begin
            errors++;
            $display("GO with an illegal function started a transfer");
         end
         // Controller clear, high byte only
         writeReg(rhPkg::rhAddrCs1, 1'b0, 1'b1, 16'h8000);
         expectReg(rhPkg::rhAddrWc, 16'h0000, "WC");
         expectReg(rhPkg::rhAddrBa, 16'h0000, "BA");
         expectReg(rhPkg::rhAddrCs1, 16'h0080, "CS1");
      end
   endtask

   //////////////////////////////
   // Memory write monitor
   //////////////////////////////

   always @(negedge clk)
   begin
      if (!rst && memWrite)
      begin
         writeCount++;
         if (expAddr.size() == 0)
         begin
            errors++;
            $display("memory write to %h at %0t with no device word pending", memReq.addr, $time);
         end
         else
         begin
            if (memReq.addr !== expAddr[0])
            begin
               errors++;
               $display("mismatch at %0t: memReq.addr expected %h got %h", $time, expAddr[0],
                        memReq.addr);
            end
            if (memReq.data !== expData[0])
            begin
               errors++;
               $display("mismatch at %0t: memReq.data expected %h got %h", $time, expData[0],
                        memReq.data);
            end
            void'(expAddr.pop_front());
            void'(expData.pop_front());
         end
      end
      if (!rst && intr)
         intrCount++;
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      rst        = 1'b1;
      regWrite   = 1'b0;
      busReq     = '0;
      regAddr    = rhPkg::rhAddrCs1;
      devStrobe  = 1'b0;
      devWord    = '0;
      lfsr       = 17'd76256;
      errors     = 0;
      timeouts   = 0;
      writeCount = 0;
      intrCount  = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset state
      if (memWrite !== 1'b0)
      begin
         errors++;
         $display("mismatch at %0t: memWrite expected 0 got %b", $time, memWrite);
      end
      if (intr !== 1'b0)
      begin
         errors++;
         $display("mismatch at %0t: intr expected 0 got %b", $time, intr);
      end
      expectReg(rhPkg::rhAddrCs1, 16'h0080, "CS1");
      expectReg(rhPkg::rhAddrWc, 16'h0000, "WC");
      expectReg(rhPkg::rhAddrBa, 16'h0000, "BA");

      laneTest(rhPkg::rhAddrWc, "WC");
      laneTest(rhPkg::rhAddrBa, "BA");

      for (int i = 0; i < numXfers; i++)
         runXfer(i);

      $display("errors %0d, timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule
